/* rv_core.f */
+incdir+.
rv_pkg.sv
rv_sequencer.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
tb_clock.sv
rv_core_tb.sv

/* Makefile */
VERILATOR  := verilator
FILELIST   := rv_core.f
TOP        := rv_core_tb
RTL_TOP    := rv_core
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int          CLK_PERIOD       = 20;
    localparam int          INSTR_PER_STORE  = 20;
    localparam int          CYCLES_PER_INSTR = 12;
    localparam int          MEM_WORDS        = 256;
    localparam logic [31:0] MEM_BYTES        = 32'd1024;
    localparam int          DATA_BASE        = 'h200;
    localparam int          SKIP_OFF         = 'h1F0;   // stores here must never happen
    localparam int          OPND_A           = 7;
    localparam int          OPND_B           = -3;
    localparam logic [31:0] KNOWN_WORD       = 32'h8001_7FF2;

    localparam logic [6:0]  OP_LUI    = 7'b0110111;
    localparam logic [6:0]  OP_JAL    = 7'b1101111;
    localparam logic [6:0]  OP_BRANCH = 7'b1100011;
    localparam logic [6:0]  OP_LOAD   = 7'b0000011;
    localparam logic [6:0]  OP_STORE  = 7'b0100011;
    localparam logic [6:0]  OP_REG    = 7'b0110011;
    localparam logic [6:0]  OP_IMM    = 7'b0010011;

    typedef struct packed {
        logic [31:0]    adr;
        logic [31:0]    dat;
        logic [3:0]     sel;
    } store_rec_t;

    logic           clk;
    logic           reset_n;
    wb_req_t        wb;
    logic [31:0]    wb_dat;
    logic           wb_ack;

    logic [31:0]    mem [0:MEM_WORDS-1];
    logic [31:0]    prog [$];
    store_rec_t     exp_q [$];
    store_rec_t     log_q [$];
    int             result_slot;
    int             seed = 53071;
    bit             tables_ready = 1'b0;

    tb_clock tb_clock_inst
    (
        .o_clk          (clk),
        .o_reset_n      (reset_n)
    );

    rv_core rv_core_inst
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .o_wb           (wb),
        .i_wb_dat       (wb_dat),
        .i_wb_ack       (wb_ack)
    );

    function automatic logic [31:0] rtype_word(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] itype_word(int imm, int rs1, int f3, int rd,
                                               logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] stype_word(int f3, int rs2, int rs1, int off);
        return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] btype_word(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] lui_word(int rd, int imm20);
        return {imm20[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic put_instr(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic add_expected_store(input int off, input logic [31:0] dat,
                                      input logic [3:0] sel);
        exp_q.push_back('{adr: 32'(DATA_BASE + off), dat: dat, sel: sel});
    endtask

    // sw rd into the next result slot and expect that word on the bus
    task automatic store_and_expect(input int rd, input logic [31:0] expected);
        put_instr(stype_word(2, rd, 31, result_slot));
        add_expected_store(result_slot, expected, 4'b1111);
        result_slot = result_slot + 4;
    endtask

    task automatic load_and_expect(input int f3, input int off, input logic [31:0] expected);
        put_instr(itype_word(off, 31, f3, 15, OP_LOAD));
        store_and_expect(15, expected);
    endtask

    task automatic build_program();
        int             known_off;
        logic [31:0]    link_val;
        result_slot = 0;
        put_instr(itype_word(DATA_BASE, 0, 0, 31, OP_IMM));    // x31 points at the data area
        put_instr(itype_word(OPND_A, 0, 0, 1, OP_IMM));
        put_instr(itype_word(OPND_B, 0, 0, 2, OP_IMM));
        store_and_expect(1, 32'(OPND_A));
        put_instr(rtype_word(0, 0, 3, 1, 2));                  // add x3, x1, x2
        store_and_expect(3, 32'(OPND_A + OPND_B));
        put_instr(rtype_word(32, 0, 4, 1, 2));                 // sub x4, x1, x2
        store_and_expect(4, 32'(OPND_A - OPND_B));
        put_instr(rtype_word(0, 7, 5, 1, 2));                  // and x5, x1, x2
        store_and_expect(5, 32'(OPND_A & OPND_B));
        put_instr(rtype_word(0, 6, 6, 1, 2));                  // or x6, x1, x2
        store_and_expect(6, 32'(OPND_A | OPND_B));
        put_instr(rtype_word(0, 2, 7, 2, 1));                  // slt x7, x2, x1
        store_and_expect(7, 32'(OPND_B < OPND_A));
        put_instr(rtype_word(0, 2, 8, 1, 2));                  // slt x8, x1, x2
        store_and_expect(8, 32'(OPND_A < OPND_B));
        put_instr(itype_word(-2, 2, 2, 9, OP_IMM));            // slti x9, x2, -2
        store_and_expect(9, 32'(OPND_B < -2));
        put_instr(itype_word('h0F0, 2, 7, 10, OP_IMM));        // andi x10, x2, 0xf0
        store_and_expect(10, 32'(OPND_B & 'h0F0));
        put_instr(itype_word(-256, 1, 6, 11, OP_IMM));         // ori x11, x1, -256
        store_and_expect(11, 32'(OPND_A | -256));
        put_instr(lui_word(12, 'hABCDE));
        store_and_expect(12, 32'h000A_BCDE << 12);
        put_instr(rtype_word(0, 0, 0, 1, 1));                  // add x0 is thrown away
        store_and_expect(0, 32'h0);

        put_instr(lui_word(13, 'h12345));
        put_instr(itype_word('h678, 13, 0, 13, OP_IMM));       // x13 = 0x12345678
        for (int k = 0; k < 4; k++)
        begin
            put_instr(stype_word(0, 13, 31, result_slot + k));
            add_expected_store(result_slot, 32'h7878_7878, 4'b0001 << k);
        end
        result_slot = result_slot + 4;
        for (int h = 0; h < 4; h = h + 2)
        begin
            put_instr(stype_word(1, 13, 31, result_slot + h));
            add_expected_store(result_slot, 32'h5678_5678, 4'b0011 << h);
        end
        result_slot = result_slot + 4;

        put_instr(lui_word(14, 'h80018));
        put_instr(itype_word(-14, 14, 0, 14, OP_IMM));         // x14 = KNOWN_WORD
        known_off = result_slot;
        store_and_expect(14, KNOWN_WORD);
        // the known word holds bytes f2 7f 01 80 and halfwords 7ff2 8001
        load_and_expect(0, known_off, 32'hFFFF_FFF2);
        load_and_expect(0, known_off + 1, 32'h0000_007F);
        load_and_expect(0, known_off + 2, 32'h0000_0001);
        load_and_expect(0, known_off + 3, 32'hFFFF_FF80);
        load_and_expect(4, known_off, 32'h0000_00F2);
        load_and_expect(4, known_off + 1, 32'h0000_007F);
        load_and_expect(4, known_off + 2, 32'h0000_0001);
        load_and_expect(4, known_off + 3, 32'h0000_0080);
        load_and_expect(1, known_off, 32'h0000_7FF2);
        load_and_expect(1, known_off + 2, 32'hFFFF_8001);
        load_and_expect(5, known_off, 32'h0000_7FF2);
        load_and_expect(5, known_off + 2, 32'h0000_8001);
        load_and_expect(2, known_off, KNOWN_WORD);

        link_val = `RV_RESET_ADDR + 32'(4 * prog.size() + 4);
        put_instr(jal_word(16, 8));                            // jumps over the next store
        put_instr(stype_word(2, 0, 31, SKIP_OFF));
        store_and_expect(16, link_val);
        put_instr(btype_word(0, 1, 1, 8));                     // beq taken
        put_instr(stype_word(2, 1, 31, SKIP_OFF));
        put_instr(btype_word(0, 1, 2, 8));                     // beq not taken
        store_and_expect(2, 32'(OPND_B));
        put_instr(jal_word(0, 0));                             // park the core in a loop
    endtask

    task automatic load_memory();
        int base;
        base = int'(`RV_RESET_ADDR >> 2);
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hC0DE_0000 | 32'(i);
        for (int i = 0; i < prog.size(); i++)
            mem[base + i] = prog[i];
    endtask

    task automatic check_first_fetch();
        wait (reset_n === 1'b1);
        #1;
        while (!wb.stb)
        begin
            @(posedge clk);
            #1;
        end
        assert (wb.cyc && (wb.adr == `RV_RESET_ADDR) && !wb.we && (wb.sel == 4'b1111))
        else
            stop_with_failure($sformatf("ERROR at %0t ns: first request adr=%h we=%b sel=%b",
                                        $time, wb.adr, wb.we, wb.sel));
    endtask

    // the memory model acks one to four cycles after it first sees a request
    initial
    begin : bus_model
        int         wait_left;
        int         idx;
        logic       busy;
        wb_ack = 1'b0;
        wb_dat = '0;
        wait_left = 0;
        busy = 1'b0;
        wait (tables_ready);
        load_memory();
        forever
        begin
            @(posedge clk);
            #1;
            if (!reset_n || wb_ack)
            begin
                wb_ack = 1'b0;
                busy = 1'b0;
            end
            else if (wb.stb && wb.cyc)
            begin
                if (!busy)
                begin
                    busy = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                else if (wait_left > 0)
                    wait_left = wait_left - 1;
                else
                begin
                    assert (wb.adr < MEM_BYTES)
                    else
                        stop_with_failure("bus address falls outside the 1 KiB memory");
                    idx = int'(wb.adr[9:2]);
                    if (wb.we)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (wb.sel[b])
                                mem[idx][8*b +: 8] = wb.dat[8*b +: 8];
                        log_q.push_back('{adr: wb.adr, dat: wb.dat, sel: wb.sel});
                    end
                    else
                        wb_dat = mem[idx];
                    wb_ack = 1'b1;
                end
            end
        end
    end

    initial
    begin : watchdog
        int limit_ns;
        wait (tables_ready);
        limit_ns = exp_q.size() * INSTR_PER_STORE * CYCLES_PER_INSTR * CLK_PERIOD;
        #(limit_ns);
        stop_with_failure("watchdog expired before all expected stores were seen");
    end

    initial
    begin : store_check
        store_rec_t got;
        build_program();
        tables_ready = 1'b1;
        check_first_fetch();
        for (int n = 0; n < exp_q.size(); n++)
        begin
            while (log_q.size() == 0)
                @(posedge clk);
            got = log_q.pop_front();
            assert (got == exp_q[n])
            else
                stop_with_failure($sformatf(
                    "ERROR at %0t ns: store %0d got adr=%h dat=%h sel=%b, want %h %h %b",
                    $time, n, got.adr, got.dat, got.sel,
                    exp_q[n].adr, exp_q[n].dat, exp_q[n].sel));
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
(
    output logic    o_clk,
    output logic    o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
            #10 o_clk = ~o_clk;    // 20 ns period
    end

    initial
    begin
        o_reset_n = 1'b0;
        repeat (3) @(posedge o_clk);
        #1 o_reset_n = 1'b1;    // released just after the third edge
    end

endmodule

/* rv_core.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core
    import rv_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    output wb_req_t             o_wb,
    input  wire [`RV_XLEN-1:0]  i_wb_dat,
    input  wire                 i_wb_ack
);

    stage_t                     w_stage;
    logic                       w_stb;
    logic                       w_cyc;
    logic                       w_ir_load;
    logic                       w_pc_load;
    logic                       w_mem_op;
    logic                       w_exec_load;
    logic                       w_mem_load;
    logic                       w_mem_stage;
    logic [`RV_XLEN-3:0]        w_pc;
    logic [`RV_XLEN-3:0]        w_pc_p4;
    logic [`RV_REG_IDX_W-1:0]   w_rs1;
    logic [`RV_REG_IDX_W-1:0]   w_rs2;
    logic [`RV_XLEN-1:0]        w_rs1_val;
    logic [`RV_XLEN-1:0]        w_rs2_val;
    exec_t                      w_exec;
    mem_req_t                   w_mem;
    logic [`RV_XLEN-1:0]        w_lsu_adr;
    logic [`RV_XLEN-1:0]        w_lsu_dat;
    logic [3:0]                 w_lsu_sel;
    logic                       w_lsu_we;
    logic                       w_rd_we;
    logic [`RV_REG_IDX_W-1:0]   w_rd;
    logic [`RV_XLEN-1:0]        w_rd_data;
    logic                       w_pc_src;
    logic [`RV_XLEN-3:0]        w_pc_target;

    assign w_mem_op = w_exec.ctrl.mem_read | w_exec.ctrl.mem_write;
    assign w_exec_load = (w_stage == STAGE_EXECUTE);
    assign w_mem_load = ((w_stage == STAGE_MEM_WAIT) && i_wb_ack) ||
                        ((w_stage == STAGE_MEM_REQ) && !w_mem_op);   // skipped bus cycle
    assign w_mem_stage = (w_stage == STAGE_MEM_REQ) || (w_stage == STAGE_MEM_WAIT);

    rv_sequencer rv_sequencer_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_wb_ack       (i_wb_ack),
        .i_mem_op       (w_mem_op),
        .o_stage        (w_stage),
        .o_stb          (w_stb),
        .o_cyc          (w_cyc),
        .o_ir_load      (w_ir_load),
        .o_pc_load      (w_pc_load)
    );

    rv_fetch rv_fetch_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_pc_load      (w_pc_load),
        .i_pc_src       (w_pc_src),
        .i_pc_target    (w_pc_target),
        .o_pc           (w_pc),
        .o_pc_p4        (w_pc_p4)
    );

    rv_decode rv_decode_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_ir_load      (w_ir_load),
        .i_stage        (w_stage),
        .i_wb_dat       (i_wb_dat),
        .i_pc           (w_pc),
        .i_pc_p4        (w_pc_p4),
        .i_rs1_val      (w_rs1_val),
        .i_rs2_val      (w_rs2_val),
        .o_rs1          (w_rs1),
        .o_rs2          (w_rs2),
        .o_exec         (w_exec)
    );

    rv_regfile rv_regfile_inst
    (
        .i_clk          (i_clk),
        .i_rs1          (w_rs1),
        .i_rs2          (w_rs2),
        .i_we           (w_pc_load & w_rd_we),  // pc_load is the write stage pulse
        .i_rd           (w_rd),
        .i_wdata        (w_rd_data),
        .o_rs1_val      (w_rs1_val),
        .o_rs2_val      (w_rs2_val)
    );

    rv_execute rv_execute_inst
    (
        .i_clk          (i_clk),
        .i_load         (w_exec_load),
        .i_exec         (w_exec),
        .o_mem          (w_mem)
    );

    rv_lsu rv_lsu_inst
    (
        .i_clk          (i_clk),
        .i_load         (w_mem_load),
        .i_mem          (w_mem),
        .i_wb_dat       (i_wb_dat),
        .o_adr          (w_lsu_adr),
        .o_dat          (w_lsu_dat),
        .o_sel          (w_lsu_sel),
        .o_we           (w_lsu_we),
        .o_rd_we        (w_rd_we),
        .o_rd           (w_rd),
        .o_rd_data      (w_rd_data),
        .o_pc_src       (w_pc_src),
        .o_pc_target    (w_pc_target)
    );

    assign o_wb = '{
        adr: w_mem_stage ? w_lsu_adr : {w_pc, 2'b00},
        dat: w_lsu_dat,
        we:  w_mem_stage & w_lsu_we,
        sel: w_mem_stage ? w_lsu_sel : 4'b1111,
        stb: w_stb,
        cyc: w_cyc
    };

endmodule

/* rv_lsu.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_lsu
    import rv_pkg::*;
(
    input  wire                         i_clk,
    input  wire                         i_load,
    input  mem_req_t                    i_mem,
    input  wire [`RV_XLEN-1:0]          i_wb_dat,
    output logic [`RV_XLEN-1:0]         o_adr,
    output logic [`RV_XLEN-1:0]         o_dat,
    output logic [3:0]                  o_sel,
    output logic                        o_we,
    output logic                        o_rd_we,
    output logic [`RV_REG_IDX_W-1:0]    o_rd,
    output logic [`RV_XLEN-1:0]         o_rd_data,
    output logic                        o_pc_src,
    output logic [`RV_XLEN-3:0]         o_pc_target
);

    logic [1:0]             w_off;
    logic [7:0]             w_byte;
    logic [15:0]            w_half;
    logic [`RV_XLEN-1:0]    w_load_data;
    logic [`RV_XLEN-1:0]    w_result;

    assign w_off = i_mem.alu_result[1:0];
    assign o_adr = {i_mem.alu_result[`RV_XLEN-1:2], 2'b00};
    assign o_we = i_mem.ctrl.mem_write;

    // narrow stores go out on every lane and sel picks the one that lands
    always_comb
    begin
        case (i_mem.ctrl.funct3[1:0])
        2'b00:
        begin
            o_dat = {4{i_mem.store_data[7:0]}};
            o_sel = 4'b0001 << w_off;
        end
        2'b01:
        begin
            o_dat = {2{i_mem.store_data[15:0]}};
            o_sel = 4'b0011 << {w_off[1], 1'b0};
        end
        default:
        begin
            o_dat = i_mem.store_data;
            o_sel = 4'b1111;
        end
        endcase
    end

    assign w_byte = i_wb_dat[{w_off, 3'b000} +: 8];
    assign w_half = i_wb_dat[{w_off[1], 4'b0000} +: 16];

    always_comb
    begin
        case (i_mem.ctrl.funct3)
        3'b000:  w_load_data = {{24{w_byte[7]}}, w_byte};
        3'b001:  w_load_data = {{16{w_half[15]}}, w_half};
        3'b100:  w_load_data = {24'h0, w_byte};
        3'b101:  w_load_data = {16'h0, w_half};
        default: w_load_data = i_wb_dat;
        endcase
    end

    always_comb
    begin
        case (i_mem.ctrl.res_src)
        RES_LOAD: w_result = w_load_data;
        RES_LINK: w_result = {i_mem.pc_p4, 2'b00};
        default:  w_result = i_mem.alu_result;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            o_rd_we <= i_mem.ctrl.reg_write;
            o_rd <= i_mem.ctrl.rd;
            o_rd_data <= w_result;  // load data is taken in the ack cycle
            o_pc_src <= i_mem.pc_src;
            o_pc_target <= i_mem.pc_target;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_execute
    import rv_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_load,
    input  exec_t       i_exec,
    output mem_req_t    o_mem
);

    logic [`RV_XLEN-1:0]    w_op_b;
    logic [`RV_XLEN-1:0]    w_alu;
    logic                   w_pc_src;
    logic [`RV_XLEN-3:0]    w_pc_target;

    assign w_op_b = i_exec.ctrl.alu_src ? i_exec.imm : i_exec.rs2_val;

    always_comb
    begin
        case (i_exec.ctrl.alu_op)
        ALU_SUB: w_alu = i_exec.rs1_val - w_op_b;
        ALU_AND: w_alu = i_exec.rs1_val & w_op_b;
        ALU_OR:  w_alu = i_exec.rs1_val | w_op_b;
        ALU_SLT: w_alu = {{(`RV_XLEN-1){1'b0}}, $signed(i_exec.rs1_val) < $signed(w_op_b)};
        default: w_alu = i_exec.rs1_val + w_op_b;
        endcase
    end

    // beq runs a subtract, so a zero result means the operands match
    assign w_pc_src = i_exec.ctrl.jump | (i_exec.ctrl.branch & (w_alu == '0));
    assign w_pc_target = i_exec.pc + i_exec.imm[`RV_XLEN-1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            o_mem <= '{
                ctrl:       i_exec.ctrl,
                alu_result: w_alu,
                store_data: i_exec.rs2_val,
                pc_p4:      i_exec.pc_p4,
                pc_src:     w_pc_src,
                pc_target:  w_pc_target
            };
        end
    end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_regfile
(
    input  wire                         i_clk,
    input  wire [`RV_REG_IDX_W-1:0]     i_rs1,
    input  wire [`RV_REG_IDX_W-1:0]     i_rs2,
    input  wire                         i_we,
    input  wire [`RV_REG_IDX_W-1:0]     i_rd,
    input  wire [`RV_XLEN-1:0]          i_wdata,
    output logic [`RV_XLEN-1:0]         o_rs1_val,
    output logic [`RV_XLEN-1:0]         o_rs2_val
);

    logic [`RV_XLEN-1:0]    r_regs [(1 << `RV_REG_IDX_W)-1:1];  // x0 has no storage

    always_ff @(posedge i_clk)
    begin
        if (i_we && (i_rd != '0))
            r_regs[i_rd] <= i_wdata;
    end

    assign o_rs1_val = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

endmodule

/* rv_decode.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_decode
    import rv_pkg::*;
(
    input  wire                         i_clk,
    input  wire                         i_reset_n,
    input  wire                         i_ir_load,
    input  stage_t                      i_stage,
    input  wire [`RV_XLEN-1:0]          i_wb_dat,
    input  wire [`RV_XLEN-3:0]          i_pc,
    input  wire [`RV_XLEN-3:0]          i_pc_p4,
    input  wire [`RV_XLEN-1:0]          i_rs1_val,
    input  wire [`RV_XLEN-1:0]          i_rs2_val,
    output logic [`RV_REG_IDX_W-1:0]    o_rs1,
    output logic [`RV_REG_IDX_W-1:0]    o_rs2,
    output exec_t                       o_exec
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;

    instr_u                 r_ir;
    ctrl_t                  r_ctrl;
    logic [`RV_XLEN-3:0]    r_pc;
    logic [`RV_XLEN-3:0]    r_pc_p4;
    logic [`RV_XLEN-1:0]    r_imm;
    logic [`RV_XLEN-1:0]    r_rs1_val;
    logic [`RV_XLEN-1:0]    r_rs2_val;
    ctrl_t                  w_ctrl;
    logic [`RV_XLEN-1:0]    w_imm;
    logic [`RV_XLEN-1:0]    w_imm_i;
    logic [`RV_XLEN-1:0]    w_imm_s;
    logic [`RV_XLEN-1:0]    w_imm_b;
    logic [`RV_XLEN-1:0]    w_imm_u;
    logic [`RV_XLEN-1:0]    w_imm_j;
    logic                   w_load;

    always_ff @(posedge i_clk)
    begin
        if (i_ir_load)
            r_ir <= i_wb_dat;
    end

    assign w_imm_i = {{20{r_ir.i.imm[11]}}, r_ir.i.imm};
    assign w_imm_s = {{20{r_ir.s.imm_hi[6]}}, r_ir.s.imm_hi, r_ir.s.imm_lo};
    assign w_imm_b = {{19{r_ir.b.imm12}}, r_ir.b.imm12, r_ir.b.imm11,
                      r_ir.b.imm10_5, r_ir.b.imm4_1, 1'b0};
    assign w_imm_u = {r_ir.u.imm, 12'h000};
    assign w_imm_j = {{11{r_ir.j.imm20}}, r_ir.j.imm20, r_ir.j.imm19_12,
                      r_ir.j.imm11, r_ir.j.imm10_1, 1'b0};

    assign o_rs1 = (r_ir.r.opcode == OP_LUI) ? '0 : r_ir.r.rs1;  // lui is x0 + imm
    assign o_rs2 = r_ir.r.rs2;

    always_comb
    begin
        w_ctrl = '0;
        w_ctrl.funct3 = r_ir.r.funct3;
        w_ctrl.rd = r_ir.r.rd;
        w_imm = w_imm_i;
        case (r_ir.r.opcode)
        OP_LUI:
        begin
            w_ctrl.reg_write = 1'b1;
            w_ctrl.alu_src = 1'b1;
            w_imm = w_imm_u;
        end
        OP_JAL:
        begin
            w_ctrl.reg_write = 1'b1;
            w_ctrl.res_src = RES_LINK;
            w_ctrl.jump = 1'b1;
            w_imm = w_imm_j;
        end
        OP_BRANCH:
        begin
            w_ctrl.branch = (r_ir.b.funct3 == 3'b000);  // beq only
            w_ctrl.alu_op = ALU_SUB;
            w_imm = w_imm_b;
        end
        OP_LOAD:
        begin
            w_ctrl.reg_write = r_ir.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            w_ctrl.mem_read = w_ctrl.reg_write;
            w_ctrl.res_src = RES_LOAD;
            w_ctrl.alu_src = 1'b1;
        end
        OP_STORE:
        begin
            w_ctrl.mem_write = r_ir.s.funct3 inside {3'b000, 3'b001, 3'b010};
            w_ctrl.alu_src = 1'b1;
            w_imm = w_imm_s;
        end
        OP_REG, OP_IMM:
        begin
            w_ctrl.reg_write = 1'b1;
            w_ctrl.alu_src = (r_ir.r.opcode == OP_IMM);
            case (r_ir.r.funct3)
            3'b000:
            begin
                if ((r_ir.r.opcode == OP_REG) && r_ir.r.funct7[5])
                    w_ctrl.alu_op = ALU_SUB;
            end
            3'b010:  w_ctrl.alu_op = ALU_SLT;
            3'b110:  w_ctrl.alu_op = ALU_OR;
            3'b111:  w_ctrl.alu_op = ALU_AND;
            default: w_ctrl.reg_write = 1'b0;
            endcase
        end
        default: w_ctrl = '0;   // anything else retires as a no-op
        endcase
    end

    assign w_load = (i_stage == STAGE_DECODE);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_ctrl <= '0;
        else if (w_load)
            r_ctrl <= w_ctrl;
    end

    always_ff @(posedge i_clk)
    begin
        if (w_load)
        begin
            r_pc <= i_pc;
            r_pc_p4 <= i_pc_p4;
            r_imm <= w_imm;
            r_rs1_val <= i_rs1_val;
            r_rs2_val <= i_rs2_val;
        end
    end

    assign o_exec = '{
        ctrl:    r_ctrl,
        pc:      r_pc,
        pc_p4:   r_pc_p4,
        imm:     r_imm,
        rs1_val: r_rs1_val,
        rs2_val: r_rs2_val
    };

endmodule

/* rv_fetch.sv */
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_fetch
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire                     i_pc_load,
    input  wire                     i_pc_src,
    input  wire [`RV_XLEN-3:0]      i_pc_target,
    output logic [`RV_XLEN-3:0]     o_pc,
    output logic [`RV_XLEN-3:0]     o_pc_p4
);

    localparam logic [`RV_XLEN-1:0] RESET_ADDR = `RV_RESET_ADDR;

    logic [`RV_XLEN-3:0]    r_pc;   // word address without the byte offset

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_pc <= RESET_ADDR[`RV_XLEN-1:2];
        else if (i_pc_load)
            r_pc <= i_pc_src ? i_pc_target : o_pc_p4;
    end

    assign o_pc = r_pc;
    assign o_pc_p4 = r_pc + 1'b1;   // one word on

endmodule

/* rv_sequencer.sv */
`timescale 1ns/1ns

module rv_sequencer
    import rv_pkg::*;
(
    input  wire     i_clk,
    input  wire     i_reset_n,
    input  wire     i_wb_ack,
    input  wire     i_mem_op,
    output stage_t  o_stage,
    output logic    o_stb,
    output logic    o_cyc,
    output logic    o_ir_load,
    output logic    o_pc_load
);

    stage_t     r_stage;
    stage_t     w_stage_next;
    logic       w_bus_next;

    always_comb
    begin
        case (r_stage)
        STAGE_FETCH_REQ:  w_stage_next = STAGE_FETCH_WAIT;
        STAGE_FETCH_WAIT: w_stage_next = i_wb_ack ? STAGE_DECODE : STAGE_FETCH_WAIT;
        STAGE_DECODE:     w_stage_next = STAGE_EXECUTE;
        STAGE_EXECUTE:    w_stage_next = STAGE_MEM_REQ;
        STAGE_MEM_REQ:    w_stage_next = i_mem_op ? STAGE_MEM_WAIT : STAGE_WRITE;
        STAGE_MEM_WAIT:   w_stage_next = i_wb_ack ? STAGE_WRITE : STAGE_MEM_WAIT;
        default:          w_stage_next = STAGE_FETCH_REQ;
        endcase
    end

    // the bus is held for the whole fetch, and for memory stages only with a load or store
    always_comb
    begin
        case (w_stage_next)
        STAGE_FETCH_REQ, STAGE_FETCH_WAIT: w_bus_next = 1'b1;
        STAGE_MEM_REQ, STAGE_MEM_WAIT:     w_bus_next = i_mem_op;
        default:                           w_bus_next = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_stage <= STAGE_FETCH_REQ;
            o_stb <= 1'b0;
            o_cyc <= 1'b0;
        end
        else
        begin
            r_stage <= w_stage_next;
            o_stb <= w_bus_next;
            o_cyc <= w_bus_next;
        end
    end

    assign o_stage = r_stage;
    assign o_ir_load = (r_stage == STAGE_FETCH_WAIT) && i_wb_ack;   // data valid with the ack
    assign o_pc_load = (r_stage == STAGE_WRITE);

endmodule

/* rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        STAGE_FETCH_REQ  = 3'h1,
        STAGE_FETCH_WAIT = 3'h2,
        STAGE_DECODE     = 3'h3,
        STAGE_EXECUTE    = 3'h4,
        STAGE_MEM_REQ    = 3'h5,
        STAGE_MEM_WAIT   = 3'h6,
        STAGE_WRITE      = 3'h7
    } stage_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_t;

    localparam logic [1:0] RES_ALU  = 2'b00;
    localparam logic [1:0] RES_LOAD = 2'b01;
    localparam logic [1:0] RES_LINK = 2'b10;   // pc+4 for jal

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_u;

    typedef struct packed {
        logic                       reg_write;
        logic [1:0]                 res_src;
        logic                       mem_read;
        logic                       mem_write;
        logic                       jump;
        logic                       branch;
        logic                       alu_src;    // second operand is the immediate
        alu_op_t                    alu_op;
        logic [2:0]                 funct3;
        logic [`RV_REG_IDX_W-1:0]   rd;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`RV_XLEN-3:0]    pc;
        logic [`RV_XLEN-3:0]    pc_p4;
        logic [`RV_XLEN-1:0]    imm;
        logic [`RV_XLEN-1:0]    rs1_val;
        logic [`RV_XLEN-1:0]    rs2_val;
    } exec_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`RV_XLEN-1:0]    alu_result;
        logic [`RV_XLEN-1:0]    store_data;
        logic [`RV_XLEN-3:0]    pc_p4;
        logic                   pc_src;
        logic [`RV_XLEN-3:0]    pc_target;
    } mem_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    adr;
        logic [`RV_XLEN-1:0]    dat;
        logic                   we;
        logic [3:0]             sel;
        logic                   stb;
        logic                   cyc;
    } wb_req_t;

endpackage

/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_RESET_ADDR   32'h0000_0000   // first fetch address on a word boundary
`define RV_XLEN         32              // data word width
`define RV_REG_IDX_W    5               // x0 to x31

`endif
